// ==== Makefile ====
SIM      := verilator
TOP      := io_tb
FILELIST := build.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --assert --timing -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
RUN_ARGS := +verilator+error+limit+100
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx 'Regression passed'

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
verilog/io_pkg.sv
verilog/io_decoder.sv
verilog/leds_register.sv
verilog/interval_timer.sv
verilog/irq_control.sv
verilog/io_subsystem.sv
verif/io_checker.sv
verif/io_tb_clock.sv
verif/io_tb.sv

// ==== verif/io_checker.sv ====
module io_checker import io_pkg::*; (
    input  logic sys_clk,
    input  logic rst,
    input  logic io_access,
    input  logic io_ack,
    input  io_data_t io_rdata,
    input  logic intr,
    input  logic [num_leds-1:0] leds,
    input  irq_vec_t irq_test
);

timeunit 1ns;
timeprecision 100ps;

int failures = 0; // Polled by the testbench

// Outputs come out of reset cleared
reset_clears: assert property (@(posedge sys_clk)
    rst |=> !io_ack && !intr && leds == '0 && irq_test == '0)
    else begin
        failures++;
        $error("outputs not cleared after reset");
    end

ack_follows_access: assert property (@(posedge sys_clk) disable iff (rst)
    $rose(io_access) |=> io_ack)
    else begin
        failures++;
        $error("no ack one cycle after access rose");
    end

ack_single_cycle: assert property (@(posedge sys_clk) disable iff (rst)
    io_ack |=> !io_ack)
    else begin
        failures++;
        $error("ack held for more than one cycle");
    end

ack_needs_access: assert property (@(posedge sys_clk) disable iff (rst)
    io_ack |-> $past(io_access))
    else begin
        failures++;
        $error("ack without a preceding access");
    end

// OR-combined read bus must be quiet between acks
rdata_idle_zero: assert property (@(posedge sys_clk) disable iff (rst)
    !io_ack |-> io_rdata == '0)
    else begin
        failures++;
        $error("read data nonzero outside the ack cycle");
    end

endmodule

bind io_subsystem io_checker u_io_checker (
    .sys_clk   (sys_clk),
    .rst       (rst),
    .io_access (io_access),
    .io_ack    (io_ack),
    .io_rdata  (io_rdata),
    .intr      (intr),
    .leds      (leds),
    .irq_test  (irq_test)
);

// ==== verif/io_tb.sv ====
module io_tb import io_pkg::*; ();

timeunit 1ns;
timeprecision 100ps;

localparam int max_cycles = 2000; // Sequence runs a few hundred cycles at most
localparam int ack_limit = 8;

logic sys_clk;
logic rst;
logic io_access;
io_addr_t io_addr;
logic io_wr_en;
io_bytesel_t io_bytesel;
io_data_t io_wdata;
io_data_t io_rdata;
logic io_ack;
logic [num_leds-1:0] leds;
logic intr;
irq_vec_t irq_test;

int seed = 33216;
int cycle_count = 0;
logic [31:0] rand_word;
io_data_t rd_data;
io_data_t first_count;
io_data_t second_count;
logic [num_leds-1:0] led_value;
logic [6:0] test_value;
irq_vec_t test_lines;

io_tb_clock u_io_tb_clock (
    .sys_clk (sys_clk)
);

io_subsystem u_io_subsystem (
    .sys_clk    (sys_clk),
    .rst        (rst),
    .io_access  (io_access),
    .io_addr    (io_addr),
    .io_wr_en   (io_wr_en),
    .io_bytesel (io_bytesel),
    .io_wdata   (io_wdata),
    .io_rdata   (io_rdata),
    .io_ack     (io_ack),
    .leds       (leds),
    .intr       (intr),
    .irq_test   (irq_test)
);

task automatic end_with_failure();
    $display("Regression failed");
    $fatal(1, "Stopped at first error");
endtask

task automatic expect_equal(input string name, input io_data_t got, input io_data_t exp);
    if (got !== exp) begin
        $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end_with_failure();
    end
endtask

// One host cycle, held until the ack shows up
task automatic host_access(input io_addr_t addr, input logic write, input io_bytesel_t bytesel,
                           input io_data_t wdata, output io_data_t rdata);
    int waited = 0;
    @(posedge sys_clk);
    #1;
    io_access = 1'b1;
    io_addr = addr;
    io_wr_en = write;
    io_bytesel = bytesel;
    io_wdata = wdata;
    do begin
        @(posedge sys_clk);
        #1;
        waited++;
    end while (!io_ack && waited < ack_limit);
    if (!io_ack) begin
        $display("ERROR: no ack for port 0x%h", {addr, 1'b0});
        end_with_failure();
    end
    rdata = io_rdata;
    io_access = 1'b0;
    io_wr_en = 1'b0;
endtask

task automatic host_write(input io_addr_t addr, input io_bytesel_t bytesel, input io_data_t data);
    io_data_t unused;
    host_access(addr, 1'b1, bytesel, data, unused);
endtask

task automatic host_read(input io_addr_t addr, output io_data_t data);
    host_access(addr, 1'b0, 2'b11, 16'h0000, data);
endtask

task automatic wait_for_intr(input int limit);
    int waited = 0;
    while (!intr && waited < limit) begin
        @(posedge sys_clk);
        #1;
        waited++;
    end
    if (!intr) begin
        $display("ERROR: intr did not rise within %0d cycles", limit);
        end_with_failure();
    end
endtask

always @(posedge sys_clk) begin
    cycle_count <= cycle_count + 1;
    if (u_io_subsystem.u_io_checker.failures != 0) begin
        $display("ERROR: a bus protocol assertion failed");
        end_with_failure();
    end else if (cycle_count >= max_cycles) begin
        $display("ERROR: timeout, sequence not finished after %0d cycles", max_cycles);
        end_with_failure();
    end
end

initial begin
    rst = 1'b1;
    io_access = 1'b0;
    io_addr = '0;
    io_wr_en = 1'b0;
    io_bytesel = '0;
    io_wdata = '0;
    repeat (8) @(posedge sys_clk);
    #1;
    rst = 1'b0;
    expect_equal("io_ack", io_data_t'(io_ack), 16'h0000);
    expect_equal("intr", io_data_t'(intr), 16'h0000);
    expect_equal("leds", io_data_t'(leds), 16'h0000);

    // Unmapped port, acked by the decoder and read as zero
    host_write(15'h1234, 2'b11, 16'hbeef);
    host_read(15'h1234, rd_data);
    expect_equal("io_rdata", rd_data, 16'h0000);

    rand_word = $random(seed);
    led_value = rand_word[7:0];
    host_write(leds_port, 2'b01, {rand_word[15:8], led_value});
    expect_equal("leds", io_data_t'(leds), io_data_t'(led_value));
    host_read(leds_port, rd_data);
    expect_equal("leds_rdata", rd_data, io_data_t'(led_value));
    host_write(leds_port, 2'b10, ~{rand_word[15:8], led_value}); // Lane 0 off
    expect_equal("leds", io_data_t'(leds), io_data_t'(led_value));

    host_write(timer_reload_port, 2'b11, 16'd10);
    host_write(timer_control_port, 2'b11, 16'h0001);
    host_read(timer_control_port, rd_data);
    expect_equal("timer_enable", rd_data, 16'h0001);
    wait_for_intr(3 * 11);
    host_read(irq_control_port, rd_data);
    expect_equal("pending_bit0", io_data_t'(rd_data[timer_irq_bit]), 16'h0001);

    // Reads start two cycles apart, so keep clear of the reload
    first_count = '0;
    for (int i = 0; i < 6 && first_count < 16'd2; i++)
        host_read(timer_reload_port, first_count);
    host_read(timer_reload_port, second_count);
    expect_equal("timer_count", second_count, io_data_t'(first_count - 16'd2));

    host_write(timer_control_port, 2'b11, 16'h0000);
    host_write(irq_control_port, 2'b10, 16'h0100);
    expect_equal("intr", io_data_t'(intr), 16'h0000);
    host_read(irq_control_port, rd_data);
    expect_equal("irq_rdata", rd_data, 16'h0000);

    rand_word = $random(seed);
    test_value = rand_word[6:0];
    if (test_value == '0)
        test_value = 7'h01;
    test_lines = {test_value, 1'b0}; // Line 0 is the timer
    host_write(irq_control_port, 2'b01, io_data_t'(test_value));
    expect_equal("irq_test", io_data_t'(irq_test), io_data_t'(test_lines));
    expect_equal("intr", io_data_t'(intr), 16'h0001);
    host_read(irq_control_port, rd_data);
    expect_equal("irq_rdata", rd_data, {test_lines, test_lines});
    host_write(irq_control_port, 2'b11, {test_lines, 8'h00});
    expect_equal("intr", io_data_t'(intr), 16'h0000);
    expect_equal("irq_test", io_data_t'(irq_test), 16'h0000);

    repeat (4) @(posedge sys_clk);
    #1;
    if (u_io_subsystem.u_io_checker.failures == 0) begin
        $display("Regression passed");
        $finish;
    end else begin
        $display("Regression failed");
        $fatal(1, "Bus protocol assertions failed");
    end
end

endmodule

// ==== verif/io_tb_clock.sv ====
module io_tb_clock (
    output logic sys_clk
);

timeunit 1ns;
timeprecision 100ps;

initial sys_clk = 1'b0;

always #2 sys_clk = ~sys_clk; // 4 ns period

endmodule

// ==== verilog/interval_timer.sv ====
module interval_timer import io_pkg::*; (
    input  logic sys_clk,
    input  logic rst,
    input  logic cs,
    input  logic io_wr_en,
    input  io_addr_t io_addr,
    input  io_data_t io_wdata,
    output logic timer_ack,
    output io_data_t timer_rdata,
    output logic timer_tick
);

timer_state_t state;
timer_count_t reload;
timer_count_t count;
logic cs_q;
logic start;
logic ctrl_sel;
logic wr_reload;
logic wr_ctrl;
logic enabled;

assign start = cs & ~cs_q;
assign ctrl_sel = io_addr[1]; // Set for the control port
assign wr_reload = start & io_wr_en & ~ctrl_sel;
assign wr_ctrl = start & io_wr_en & ctrl_sel;
assign enabled = state == timer_counting;

// Bus side
always_ff @(posedge sys_clk) begin
    if (rst) begin
        cs_q <= 1'b0;
        timer_ack <= 1'b0;
        timer_rdata <= '0;
    end else begin
        cs_q <= cs;
        timer_ack <= start;
        timer_rdata <= '0;
        if (start && !io_wr_en)
            timer_rdata <= ctrl_sel ? io_data_t'(enabled) : count; // Live count
    end
end

always_ff @(posedge sys_clk) begin
    if (rst)
        reload <= '0;
    else if (wr_reload)
        reload <= io_wdata;
end

// Count down to zero, then reload and tick: N+1 cycles per period
always_ff @(posedge sys_clk) begin
    if (rst) begin
        state <= timer_idle;
        count <= '0;
        timer_tick <= 1'b0;
    end else begin
        timer_tick <= 1'b0;
        if (wr_ctrl) begin
            if (io_wdata[timer_enable_bit]) begin
                count <= reload;
                state <= timer_counting;
            end else begin
                state <= timer_idle; // Count holds where it stopped
            end
        end else begin
            case (state)
            timer_counting: begin
                if (count == '0) begin
                    count <= reload;
                    timer_tick <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end
            default: ;
            endcase
        end
    end
end

endmodule

// ==== verilog/io_decoder.sv ====
module io_decoder import io_pkg::*; (
    input  logic sys_clk,
    input  logic rst,
    input  logic io_access,
    input  io_addr_t io_addr,
    output logic leds_cs,
    output logic timer_cs,
    output logic irq_cs,
    output logic default_ack
);

logic default_sel;
logic default_q;

always_comb begin
    leds_cs = 1'b0;
    timer_cs = 1'b0;
    irq_cs = 1'b0;
    default_sel = 1'b0;

    if (io_access) begin
        priority case (io_addr)
        leds_port: leds_cs = 1'b1;
        irq_control_port: irq_cs = 1'b1;
        // Both timer ports go to the one target
        timer_reload_port, timer_control_port: timer_cs = 1'b1;
        default: default_sel = 1'b1; // Unmapped port
        endcase
    end
end

// Unmapped accesses still need an ack, one per access
always_ff @(posedge sys_clk) begin
    if (rst) begin
        default_q <= 1'b0;
        default_ack <= 1'b0;
    end else begin
        default_q <= default_sel;
        default_ack <= default_sel & ~default_q;
    end
end

endmodule

// ==== verilog/io_pkg.sv ====
package io_pkg;

// Port bits 15..1, bit 0 is implied by the byte lanes
typedef logic [15:1] io_addr_t;
typedef logic [15:0] io_data_t;
typedef logic [1:0] io_bytesel_t;
typedef logic [7:0] irq_vec_t;
typedef logic [15:0] timer_count_t;

typedef enum logic {
    timer_idle,
    timer_counting
} timer_state_t;

// Word addresses of the mapped ports
localparam io_addr_t leds_port = 15'h7fff;          // Port 0xfffe
localparam io_addr_t irq_control_port = 15'h7ffb;   // Port 0xfff6
localparam io_addr_t timer_reload_port = 15'h0020;  // Port 0x0040
localparam io_addr_t timer_control_port = 15'h0021; // Port 0x0042

// Timer control register
localparam int timer_enable_bit = 0;

// Interrupt line driven by the timer tick
localparam int timer_irq_bit = 0;

localparam int num_leds = 8;

endpackage

// ==== verilog/io_subsystem.sv ====
module io_subsystem import io_pkg::*; (
    input  logic sys_clk,
    input  logic rst,
    input  logic io_access,
    input  io_addr_t io_addr,
    input  logic io_wr_en,
    input  io_bytesel_t io_bytesel,
    input  io_data_t io_wdata,
    output io_data_t io_rdata,
    output logic io_ack,
    output logic [num_leds-1:0] leds,
    output logic intr,
    output irq_vec_t irq_test
);

logic leds_cs;
logic timer_cs;
logic irq_cs;
logic leds_ack;
logic timer_ack;
logic irq_ack;
logic default_ack;
logic timer_tick;
io_data_t leds_rdata;
io_data_t timer_rdata;
io_data_t irq_rdata;

// Idle targets drive zero, so plain OR is enough
assign io_ack = leds_ack | timer_ack | irq_ack | default_ack;
assign io_rdata = leds_rdata | timer_rdata | irq_rdata;

io_decoder u_io_decoder (
    .sys_clk     (sys_clk),
    .rst         (rst),
    .io_access   (io_access),
    .io_addr     (io_addr),
    .leds_cs     (leds_cs),
    .timer_cs    (timer_cs),
    .irq_cs      (irq_cs),
    .default_ack (default_ack)
);

leds_register u_leds_register (
    .sys_clk    (sys_clk),
    .rst        (rst),
    .cs         (leds_cs),
    .io_wr_en   (io_wr_en),
    .io_bytesel (io_bytesel),
    .io_wdata   (io_wdata),
    .leds_ack   (leds_ack),
    .leds_rdata (leds_rdata),
    .leds       (leds)
);

interval_timer u_interval_timer (
    .sys_clk     (sys_clk),
    .rst         (rst),
    .cs          (timer_cs),
    .io_wr_en    (io_wr_en),
    .io_addr     (io_addr),
    .io_wdata    (io_wdata),
    .timer_ack   (timer_ack),
    .timer_rdata (timer_rdata),
    .timer_tick  (timer_tick)
);

irq_control u_irq_control (
    .sys_clk    (sys_clk),
    .rst        (rst),
    .cs         (irq_cs),
    .io_wr_en   (io_wr_en),
    .io_bytesel (io_bytesel),
    .io_wdata   (io_wdata),
    .timer_tick (timer_tick),
    .irq_ack    (irq_ack),
    .irq_rdata  (irq_rdata),
    .irq_test   (irq_test),
    .intr       (intr)
);

endmodule

// ==== verilog/irq_control.sv ====
module irq_control import io_pkg::*; (
    input  logic sys_clk,
    input  logic rst,
    input  logic cs,
    input  logic io_wr_en,
    input  io_bytesel_t io_bytesel,
    input  io_data_t io_wdata,
    input  logic timer_tick,
    output logic irq_ack,
    output io_data_t irq_rdata,
    output irq_vec_t irq_test,
    output logic intr
);

irq_vec_t pending;
irq_vec_t pending_next;
irq_vec_t test_next;
irq_vec_t clear_mask;
irq_vec_t tick_vec;
logic cs_q;
logic start;
logic wr;

assign start = cs & ~cs_q;
assign wr = start & io_wr_en;

always_comb begin
    test_next = irq_test;
    clear_mask = '0;
    tick_vec = '0;

    // Test lines sit above the timer line
    if (wr && io_bytesel[0])
        test_next = {io_wdata[6:0], 1'b0};
    if (wr && io_bytesel[1])
        clear_mask = io_wdata[15:8]; // Write one to clear

    tick_vec[timer_irq_bit] = timer_tick;
    // New sources win over a clear in the same cycle
    pending_next = (pending & ~clear_mask) | test_next | tick_vec;
end

always_ff @(posedge sys_clk) begin
    if (rst) begin
        cs_q <= 1'b0;
        irq_ack <= 1'b0;
        irq_rdata <= '0;
        irq_test <= '0;
        pending <= '0;
        intr <= 1'b0;
    end else begin
        cs_q <= cs;
        irq_ack <= start;
        irq_rdata <= '0;
        if (start && !io_wr_en)
            irq_rdata <= {irq_test, pending};
        irq_test <= test_next;
        pending <= pending_next;
        intr <= |pending_next; // Tracks pending without extra delay
    end
end

endmodule

// ==== verilog/leds_register.sv ====
module leds_register import io_pkg::*; (
    input  logic sys_clk,
    input  logic rst,
    input  logic cs,
    input  logic io_wr_en,
    input  io_bytesel_t io_bytesel,
    input  io_data_t io_wdata,
    output logic leds_ack,
    output io_data_t leds_rdata,
    output logic [num_leds-1:0] leds
);

logic cs_q;
logic start;

assign start = cs & ~cs_q; // First cycle of the access

always_ff @(posedge sys_clk) begin
    if (rst) begin
        cs_q <= 1'b0;
        leds_ack <= 1'b0;
        leds_rdata <= '0;
        leds <= '0;
    end else begin
        cs_q <= cs;
        leds_ack <= start;
        leds_rdata <= '0;
        if (start && !io_wr_en)
            leds_rdata <= io_data_t'(leds);
        if (start && io_wr_en && io_bytesel[0])
            leds <= io_wdata[num_leds-1:0];
    end
end

endmodule
